// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module vid_tb -f list.f -o vid_sim
	./obj_dir/vid_sim | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hdl/vid_cen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Clock enables: 6 MHz pixel and 3 MHz from the 24 MHz clock
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vid_cen (
    input  logic clk24,
    input  logic rst_n,
    output logic cen6,
    output logic cen3
);

    logic [2:0] cnt;

    always_ff @(posedge clk24 or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 3'd1;
        end
    end

    // Registered so both enables are clean single-cycle pulses
    always_ff @(posedge clk24 or negedge rst_n) begin
        if (!rst_n) begin
            cen6 <= 1'b0;
            cen3 <= 1'b0;
        end else begin
            cen6 <= cnt[1:0] == 2'b11;  // 1 in 4
            cen3 <= cnt == 3'b111;      // 1 in 8, always with a cen6
        end
    end

endmodule

// File: hdl/vid_char.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Char layer: tile map RAM, graphics ROM fetch FSM, pixel shifter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vid_char (
    input  logic                 clk24,
    input  logic                 rst_n,
    input  logic                 cen6,
    input  vid_pkg::vid_timing_t tim,
    input  logic                 tile_start,
    // CPU side
    input  logic                 cpu_we,
    input  logic                 map_cs,
    input  logic [9:0]           cpu_addr,
    input  logic [11:0]          cpu_din,
    // Graphics ROM
    output logic [10:0]          char_addr,
    output logic                 char_cs,
    input  logic [15:0]          char_data,
    input  logic                 char_ok,
    output vid_pkg::char_pix_t   pix
);

    vid_pkg::map_entry_t  map_ram [0:1023];
    vid_pkg::map_entry_t  map_q;
    vid_pkg::fetch_state_e state;

    logic [2:0]       row_q;        // Tile row within the 8x8 char
    logic [3:0]       pend_pal;
    logic [15:0]      pend_row;
    logic [3:0]       cur_pal;
    logic [15:0]      shift;
    logic [7:0][1:0]  blank_dl;     // {lhbl, lvbl} per step
    logic             load;
    logic [15:0]      load_row;

    assign load    = cen6 & tile_start;
    assign char_cs = (state == vid_pkg::FETCH_ROM) || (state == vid_pkg::FETCH_LOAD);

    // A fetch still running at the tile boundary is dropped, pixel 0 shown
    assign load_row = (state == vid_pkg::FETCH_IDLE) ? pend_row : 16'd0;

    // Map index is row*32 + column
    always_ff @(posedge clk24) begin
        if (cpu_we && map_cs) begin
            map_ram[cpu_addr] <= vid_pkg::map_entry_t'(cpu_din);
        end
        if (load) begin
            map_q <= map_ram[{tim.v[7:3], tim.h[7:3]}];
        end
    end

    // Fetch FSM
    always_ff @(posedge clk24 or negedge rst_n) begin
        if (!rst_n) begin
            state <= vid_pkg::FETCH_IDLE;
        end else if (load) begin
            state <= vid_pkg::FETCH_MAP;    // Restarts even if busy
        end else begin
            case (state)
                vid_pkg::FETCH_MAP: state <= vid_pkg::FETCH_ROM;
                vid_pkg::FETCH_ROM: begin
                    if (char_ok) begin
                        state <= vid_pkg::FETCH_LOAD;
                    end
                end
                vid_pkg::FETCH_LOAD: state <= vid_pkg::FETCH_IDLE;
                default: state <= vid_pkg::FETCH_IDLE;
            endcase
        end
    end

    // ROM address held from MAP until the row is latched
    always_ff @(posedge clk24) begin
        if (load) begin
            row_q <= tim.v[2:0];
        end
        if (state == vid_pkg::FETCH_MAP) begin
            char_addr <= {map_q.code, row_q};
            pend_pal  <= map_q.pal;     // Kept even if the ROM is late
        end
        if (state == vid_pkg::FETCH_LOAD) begin
            pend_row <= char_data;
        end
    end

    // Shifter, pixel 0 sits in the low bits
    always_ff @(posedge clk24) begin
        if (load) begin
            shift   <= load_row >> 2;   // Pixel 0 goes straight to pix
            cur_pal <= pend_pal;
        end else if (cen6) begin
            shift <= shift >> 2;
        end
    end

    // Blanking rides along with the pixel it belongs to
    always_ff @(posedge clk24 or negedge rst_n) begin
        if (!rst_n) begin
            blank_dl <= '0;
            pix      <= '0;
        end else if (cen6) begin
            blank_dl <= {blank_dl[6:0], {tim.lhbl, tim.lvbl}};
            pix.lhbl <= blank_dl[7][1];
            pix.lvbl <= blank_dl[7][0];
            if (tile_start) begin
                pix.pix <= load_row[1:0];
                pix.pal <= pend_pal;
            end else begin
                pix.pix <= shift[1:0];
                pix.pal <= cur_pal;
            end
        end
    end

endmodule

// File: hdl/vid_colmix.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Colour mixer: palette RAM lookup, blanking gate, sync alignment
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vid_colmix (
    input  logic               clk24,
    input  logic               rst_n,
    input  logic               cen6,
    input  vid_pkg::char_pix_t pix,
    input  logic               hs_in,
    input  logic               vs_in,
    input  logic               cpu_we,
    input  logic               pal_cs,
    input  logic [5:0]         cpu_addr,
    input  logic [11:0]        cpu_din,
    output vid_pkg::rgb_t      rgb,
    output logic               lhbl_dly,
    output logic               lvbl_dly,
    output logic               hs,
    output logic               vs
);

    // Char stage delay plus the lookup step
    localparam int SYNC_DLY = 10;

    vid_pkg::rgb_t        pal_ram [0:63];
    vid_pkg::rgb_t        pal_rd;
    logic [SYNC_DLY-1:0]  hs_dl;
    logic [SYNC_DLY-1:0]  vs_dl;

    always_ff @(posedge clk24) begin
        if (cpu_we && pal_cs) begin
            pal_ram[cpu_addr] <= vid_pkg::rgb_t'(cpu_din);
        end
    end

    assign pal_rd = pal_ram[{pix.pal, pix.pix}];   // 16 palettes of 4

    always_ff @(posedge clk24 or negedge rst_n) begin
        if (!rst_n) begin
            rgb      <= '0;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            hs_dl    <= '0;
            vs_dl    <= '0;
        end else if (cen6) begin
            rgb      <= (pix.lhbl && pix.lvbl) ? pal_rd : '0;  // Black in blanking
            lhbl_dly <= pix.lhbl;
            lvbl_dly <= pix.lvbl;
            hs_dl    <= {hs_dl[SYNC_DLY-2:0], hs_in};
            vs_dl    <= {vs_dl[SYNC_DLY-2:0], vs_in};
        end
    end

    assign hs = hs_dl[SYNC_DLY-1];
    assign vs = vs_dl[SYNC_DLY-1];

endmodule

// File: hdl/vid_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video path types: timing, map entry, char pixel and colour structs,
// char fetch states and default frame sizes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package vid_pkg;

    // Default frame, 6 MHz pixel clock
    localparam int H_TOTAL_DEF = 384;
    localparam int V_TOTAL_DEF = 262;
    localparam int H_VIS_DEF   = 256;
    localparam int V_VIS_DEF   = 224;
    localparam int H_SYNC_DEF  = 304;   // Sync start, pixels
    localparam int V_SYNC_DEF  = 232;   // Sync start, lines

    // Timer output, blanking bits high while visible
    typedef struct packed {
        logic [8:0] h;
        logic [8:0] v;
        logic       lhbl;
        logic       lvbl;
        logic       hs;
        logic       vs;
    } vid_timing_t;

    // Tile map entry as written by the CPU
    typedef struct packed {
        logic [3:0] pal;
        logic [7:0] code;
    } map_entry_t;

    // One pixel out of the char layer
    typedef struct packed {
        logic [3:0] pal;
        logic [1:0] pix;
        logic       lhbl;
        logic       lvbl;
    } char_pix_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_MAP,
        FETCH_ROM,
        FETCH_LOAD
    } fetch_state_e;

endpackage

// File: hdl/vid_timer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video timer: H/V counters, blanking, sync and tile boundary strobe
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vid_timer #(
    parameter int H_TOTAL = 384,
    parameter int V_TOTAL = 262,
    parameter int H_VIS   = 256,
    parameter int V_VIS   = 224,
    parameter int H_SYNC  = 304,
    parameter int V_SYNC  = 232
) (
    input  logic                 clk24,
    input  logic                 rst_n,
    input  logic                 cen6,
    output vid_pkg::vid_timing_t tim,
    output logic                 tile_start
);

    // Sync widths are fixed by the monitor standard, not the frame size
    localparam int HS_LEN = 32;
    localparam int VS_LEN = 4;

    localparam logic [8:0] H_END  = 9'(H_TOTAL - 1);
    localparam logic [8:0] V_END  = 9'(V_TOTAL - 1);
    localparam logic [8:0] H_VISL = 9'(H_VIS);
    localparam logic [8:0] V_VISL = 9'(V_VIS);
    localparam logic [8:0] HS_ON  = 9'(H_SYNC);
    localparam logic [8:0] HS_OFF = 9'(H_SYNC + HS_LEN);
    localparam logic [8:0] VS_ON  = 9'(V_SYNC);
    localparam logic [8:0] VS_OFF = 9'(V_SYNC + VS_LEN);

    logic [8:0] h_nxt;
    logic [8:0] v_nxt;

    always_comb begin
        h_nxt = tim.h + 9'd1;
        v_nxt = tim.v;
        if (tim.h == H_END) begin
            h_nxt = '0;
            v_nxt = (tim.v == V_END) ? 9'd0 : tim.v + 9'd1;
        end
    end

    // Levels decoded from the next count so they line up with h and v
    always_ff @(posedge clk24 or negedge rst_n) begin
        if (!rst_n) begin
            tim.h      <= H_END;    // First step lands on 0,0
            tim.v      <= V_END;
            tim.lhbl   <= 1'b0;
            tim.lvbl   <= 1'b0;
            tim.hs     <= 1'b0;
            tim.vs     <= 1'b0;
            tile_start <= 1'b0;
        end else if (cen6) begin
            tim.h      <= h_nxt;
            tim.v      <= v_nxt;
            tim.lhbl   <= h_nxt < H_VISL;
            tim.lvbl   <= v_nxt < V_VISL;
            tim.hs     <= (h_nxt >= HS_ON) && (h_nxt < HS_OFF);
            tim.vs     <= (v_nxt >= VS_ON) && (v_nxt < VS_OFF);
            tile_start <= h_nxt[2:0] == 3'd0;
        end
    end

endmodule

// File: hdl/vid_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Character layer video pipeline: cen, timer, char and colour mixer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vid_top #(
    parameter int H_TOTAL = vid_pkg::H_TOTAL_DEF,
    parameter int V_TOTAL = vid_pkg::V_TOTAL_DEF,
    parameter int H_VIS   = vid_pkg::H_VIS_DEF,
    parameter int V_VIS   = vid_pkg::V_VIS_DEF,
    parameter int H_SYNC  = vid_pkg::H_SYNC_DEF,
    parameter int V_SYNC  = vid_pkg::V_SYNC_DEF
) (
    input  logic        clk24,
    input  logic        rst_n,
    // CPU write port
    input  logic        cpu_we,
    input  logic        map_cs,
    input  logic        pal_cs,
    input  logic [9:0]  cpu_addr,
    input  logic [11:0] cpu_din,
    // Graphics ROM
    output logic [10:0] char_addr,
    output logic        char_cs,
    input  logic [15:0] char_data,
    input  logic        char_ok,
    // Video out
    output logic [3:0]  red,
    output logic [3:0]  green,
    output logic [3:0]  blue,
    output logic        lhbl_dly,
    output logic        lvbl_dly,
    output logic        hs,
    output logic        vs
);

    logic                 cen6;
    logic                 tile_start;
    vid_pkg::vid_timing_t tim;
    vid_pkg::char_pix_t   pix;
    vid_pkg::rgb_t        rgb;

    vid_cen i_cen (
        .clk24 ( clk24 ),
        .rst_n ( rst_n ),
        .cen6  ( cen6  ),
        .cen3  (       )    // No 3 MHz user in this layer
    );

    vid_timer #(
        .H_TOTAL ( H_TOTAL ),
        .V_TOTAL ( V_TOTAL ),
        .H_VIS   ( H_VIS   ),
        .V_VIS   ( V_VIS   ),
        .H_SYNC  ( H_SYNC  ),
        .V_SYNC  ( V_SYNC  )
    ) i_timer (
        .clk24      ( clk24      ),
        .rst_n      ( rst_n      ),
        .cen6       ( cen6       ),
        .tim        ( tim        ),
        .tile_start ( tile_start )
    );

    vid_char i_char (
        .clk24      ( clk24      ),
        .rst_n      ( rst_n      ),
        .cen6       ( cen6       ),
        .tim        ( tim        ),
        .tile_start ( tile_start ),
        .cpu_we     ( cpu_we     ),
        .map_cs     ( map_cs     ),
        .cpu_addr   ( cpu_addr   ),
        .cpu_din    ( cpu_din    ),
        .char_addr  ( char_addr  ),
        .char_cs    ( char_cs    ),
        .char_data  ( char_data  ),
        .char_ok    ( char_ok    ),
        .pix        ( pix        )
    );

    vid_colmix i_colmix (
        .clk24    ( clk24         ),
        .rst_n    ( rst_n         ),
        .cen6     ( cen6          ),
        .pix      ( pix           ),
        .hs_in    ( tim.hs        ),
        .vs_in    ( tim.vs        ),
        .cpu_we   ( cpu_we        ),
        .pal_cs   ( pal_cs        ),
        .cpu_addr ( cpu_addr[5:0] ),    // 64 entry palette
        .cpu_din  ( cpu_din       ),
        .rgb      ( rgb           ),
        .lhbl_dly ( lhbl_dly      ),
        .lvbl_dly ( lvbl_dly      ),
        .hs       ( hs            ),
        .vs       ( vs            )
    );

    assign red   = rgb.r;
    assign green = rgb.g;
    assign blue  = rgb.b;

endmodule

// File: list.f
hdl/vid_pkg.sv
hdl/vid_cen.sv
hdl/vid_timer.sv
hdl/vid_char.sv
hdl/vid_colmix.sv
hdl/vid_top.sv
tests/vid_chk.sv
tests/vid_tb.sv

// File: tests/vid_chk.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Assertions on vid_top: ROM address, pixel enable, blanking
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vid_chk (
    input logic        clk24,
    input logic        rst_n,
    input logic        cen6,
    input logic        char_cs,
    input logic        char_ok,
    input logic [10:0] char_addr,
    input logic [3:0]  red,
    input logic [3:0]  green,
    input logic [3:0]  blue,
    input logic        lhbl_dly,
    input logic        lvbl_dly
);

    int fails;

    // ROM may take its time, the address must wait for it
    addr_stable: assert property (@(posedge clk24) disable iff (!rst_n)
        (char_cs && !char_ok && $past(char_cs)) |-> $stable(char_addr))
        else begin
            fails++;
            $error("char_addr moved while waiting for char_ok");
        end

    cen6_single: assert property (@(posedge clk24) disable iff (!rst_n)
        cen6 |=> !cen6)
        else begin
            fails++;
            $error("cen6 high on two cycles in a row");
        end

    blank_black: assert property (@(posedge clk24) disable iff (!rst_n)
        (!lhbl_dly || !lvbl_dly) |-> ({red, green, blue} == 12'd0))
        else begin
            fails++;
            $error("colour not black during blanking");
        end

endmodule

bind vid_top vid_chk i_chk (
    .clk24     ( clk24     ),
    .rst_n     ( rst_n     ),
    .cen6      ( cen6      ),
    .char_cs   ( char_cs   ),
    .char_ok   ( char_ok   ),
    .char_addr ( char_addr ),
    .red       ( red       ),
    .green     ( green     ),
    .blue      ( blue      ),
    .lhbl_dly  ( lhbl_dly  ),
    .lvbl_dly  ( lvbl_dly  )
);

// File: tests/vid_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for vid_top: clock, reset, ROM model, CPU writes,
// pixel monitor and directed tests
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vid_tb;

    localparam int H_TOTAL    = 64;
    localparam int V_TOTAL    = 24;
    localparam int H_VIS      = 32;
    localparam int V_VIS      = 16;
    localparam int H_SYNC     = 36;
    localparam int V_SYNC     = 18;
    localparam int WAIT_LIMIT = 20000;  // clk24 cycles, well over one frame

    logic        clk24;
    logic        rst_n;
    logic        cpu_we;
    logic        map_cs;
    logic        pal_cs;
    logic [9:0]  cpu_addr;
    logic [11:0] cpu_din;
    logic [10:0] char_addr;
    logic        char_cs;
    logic [15:0] char_data;
    logic        char_ok;
    logic [3:0]  red;
    logic [3:0]  green;
    logic [3:0]  blue;
    logic        lhbl_dly;
    logic        lvbl_dly;
    logic        hs;
    logic        vs;

    // Reference copies of what was written
    vid_pkg::map_entry_t map_mem [0:1023];
    vid_pkg::rgb_t       pal_mem [0:63];
    logic [15:0]         rom_tab [0:2047];

    int lat_lo;
    int lat_hi;
    int rom_cnt;
    int rom_lat;
    int errors;
    int checks;
    int tests;
    bit timed_out;
    bit check_en;
    bit late_mode;

    // Monitor state
    int phase;
    int x;
    int y;
    int run_len;
    int vis_lines;
    int line_runs;
    int bad_runs;
    int hs_rises;
    int vs_rises;
    int frames;
    int snap_lines;
    int snap_runs;
    int snap_bad;
    int snap_hs;
    int snap_vs;
    int px_checked;
    bit prev_lh;
    bit prev_lv;
    bit prev_hs;
    bit prev_vs;

    initial clk24 = 1'b0;
    always #5 clk24 = ~clk24;

    vid_top #(
        .H_TOTAL ( H_TOTAL ),
        .V_TOTAL ( V_TOTAL ),
        .H_VIS   ( H_VIS   ),
        .V_VIS   ( V_VIS   ),
        .H_SYNC  ( H_SYNC  ),
        .V_SYNC  ( V_SYNC  )
    ) i_vid_top (
        .clk24     ( clk24     ),
        .rst_n     ( rst_n     ),
        .cpu_we    ( cpu_we    ),
        .map_cs    ( map_cs    ),
        .pal_cs    ( pal_cs    ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_din   ( cpu_din   ),
        .char_addr ( char_addr ),
        .char_cs   ( char_cs   ),
        .char_data ( char_data ),
        .char_ok   ( char_ok   ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      ),
        .lhbl_dly  ( lhbl_dly  ),
        .lvbl_dly  ( lvbl_dly  ),
        .hs        ( hs        ),
        .vs        ( vs        )
    );

    // ROM model, answers after a random number of cycles
    always @(posedge clk24 or negedge rst_n) begin
        if (!rst_n) begin
            char_ok   <= 1'b0;
            char_data <= '0;
            rom_cnt   <= 0;
            rom_lat   <= 1;
        end else if (!char_cs) begin
            char_ok <= 1'b0;
            rom_cnt <= 0;
            rom_lat <= lat_lo + int'($urandom % (lat_hi - lat_lo + 1));
        end else if (!char_ok) begin
            if (rom_cnt + 1 >= rom_lat) begin
                char_ok   <= 1'b1;
                char_data <= rom_tab[char_addr];
            end
            rom_cnt <= rom_cnt + 1;
        end
    end

    task automatic check_rgb(input string name, input vid_pkg::rgb_t got,
                             input vid_pkg::rgb_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // One sample per pixel step, taken mid-cycle where outputs are stable
    always @(negedge clk24) begin
        vid_pkg::rgb_t       got;
        vid_pkg::rgb_t       exp;
        vid_pkg::map_entry_t e;
        logic [15:0]         d;
        logic [1:0]          p;
        int                  idx;
        if (!rst_n) begin
            phase = 0;
        end else begin
            phase = (phase + 1) % 4;
        end
        if (rst_n && phase == 0) begin
            got = {red, green, blue};
            if (prev_lv && !lvbl_dly) begin     // End of visible frame
                snap_lines = vis_lines;
                snap_runs  = line_runs;
                snap_bad   = bad_runs;
                snap_hs    = hs_rises;
                snap_vs    = vs_rises;
                vis_lines  = 0;
                line_runs  = 0;
                bad_runs   = 0;
                hs_rises   = 0;
                vs_rises   = 0;
                frames++;
            end
            if (lhbl_dly && !prev_lh) begin
                x       = 0;
                run_len = 1;
                y       = (lvbl_dly && !prev_lv) ? 0 : y + 1;
                if (lvbl_dly) begin
                    vis_lines++;
                end
            end else if (lhbl_dly) begin
                x++;
                run_len++;
            end
            if (prev_lh && !lhbl_dly) begin
                line_runs++;
                if (run_len != H_VIS) begin
                    bad_runs++;
                end
            end
            if (hs && !prev_hs) hs_rises++;
            if (vs && !prev_vs) vs_rises++;
            if (!lhbl_dly || !lvbl_dly) begin
                check_rgb("rgb in blanking", got, '0);
            end else if (check_en) begin
                e   = map_mem[(y / 8) * 32 + x / 8];
                d   = rom_tab[{e.code, 3'(y % 8)}];
                p   = late_mode ? 2'd0 : d[2 * (x % 8) +: 2];
                idx = int'({e.pal, p});
                exp = pal_mem[idx];
                check_rgb("rgb", got, exp);
                px_checked++;
            end
            prev_lh = lhbl_dly;
            prev_lv = lvbl_dly;
            prev_hs = hs;
            prev_vs = vs;
        end
    end

    task automatic wait_frame_end();
        int start;
        int n;
        start = frames;
        n     = 0;
        while (frames == start && n < WAIT_LIMIT && !timed_out) begin
            @(posedge clk24);
            n++;
        end
        if (frames == start && !timed_out) begin
            timed_out = 1'b1;
            $display("Timeout: no end of frame within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic cpu_write(input bit to_pal, input int addr, input logic [11:0] data);
        @(posedge clk24);
        cpu_we   <= 1'b1;
        map_cs   <= !to_pal;
        pal_cs   <= to_pal;
        cpu_addr <= 10'(addr);
        cpu_din  <= data;
        @(posedge clk24);
        cpu_we   <= 1'b0;
        map_cs   <= 1'b0;
        pal_cs   <= 1'b0;
    endtask

    task automatic fill_memories();
        vid_pkg::map_entry_t e;
        for (int r = 0; r < 3; r++) begin       // Rows past the frame are fetched too
            for (int c = 0; c < 8; c++) begin
                e.code = 8'($urandom);
                e.pal  = 4'($urandom);
                map_mem[r * 32 + c] = e;
                cpu_write(1'b0, r * 32 + c, e);
            end
        end
        for (int i = 0; i < 64; i++) begin
            pal_mem[i] = 12'(i * 67 + 5);       // All distinct
            cpu_write(1'b1, i, pal_mem[i]);
        end
    endtask

    // Settle one frame, then compare every visible pixel of the next
    task automatic check_image_frame();
        wait_frame_end();
        px_checked = 0;
        check_en   = 1'b1;
        wait_frame_end();
        check_en   = 1'b0;
        check_count("pixels checked", px_checked, H_VIS * V_VIS);
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors == err_before && !timed_out) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    // Outputs while rst_n is still low
    task automatic test_reset_values();
        int e0;
        e0 = errors;
        @(negedge clk24);
        check_level("char_cs", char_cs, 1'b0);
        check_level("hs", hs, 1'b0);
        check_level("vs", vs, 1'b0);
        check_level("lhbl_dly", lhbl_dly, 1'b0);
        check_level("lvbl_dly", lvbl_dly, 1'b0);
        check_rgb("rgb after reset", {red, green, blue}, '0);
        report_test("reset_values", e0);
    endtask

    task automatic test_frame_timing();
        int e0;
        e0 = errors;
        wait_frame_end();
        wait_frame_end();
        check_count("visible lines", snap_lines, V_VIS);
        check_count("lines per frame", snap_runs, V_TOTAL);
        check_count("short or long lines", snap_bad, 0);
        check_count("hs pulses", snap_hs, V_TOTAL);
        check_count("vs pulses", snap_vs, 1);
        report_test("frame_timing", e0);
    endtask

    task automatic test_tile_image();
        int e0;
        e0        = errors;
        lat_lo    = 1;
        lat_hi    = 1;
        late_mode = 1'b0;
        check_image_frame();
        report_test("tile_image", e0);
    endtask

    task automatic test_palette_update();
        int            e0;
        int            idx;
        vid_pkg::rgb_t nc;
        e0 = errors;
        wait_frame_end();
        // Entry used by the top left pixel
        idx = int'({map_mem[0].pal, rom_tab[{map_mem[0].code, 3'd0}][1:0]});
        nc  = ~pal_mem[idx];
        pal_mem[idx] = nc;
        cpu_write(1'b1, idx, nc);
        px_checked = 0;
        check_en   = 1'b1;
        wait_frame_end();
        check_en   = 1'b0;
        check_count("pixels checked", px_checked, H_VIS * V_VIS);
        report_test("palette_update", e0);
    endtask

    task automatic test_slow_rom();
        int e0;
        e0     = errors;
        lat_lo = 1;
        lat_hi = 20;
        check_image_frame();
        report_test("slow_rom", e0);
    endtask

    task automatic test_late_rom();
        int e0;
        e0        = errors;
        lat_lo    = 41;
        lat_hi    = 60;
        wait_frame_end();
        late_mode = 1'b1;
        check_image_frame();
        late_mode = 1'b0;
        report_test("late_rom", e0);
    endtask

    initial begin
        int seed_val;
        seed_val  = $urandom(40655);
        rst_n     = 1'b0;
        cpu_we    = 1'b0;
        map_cs    = 1'b0;
        pal_cs    = 1'b0;
        cpu_addr  = '0;
        cpu_din   = '0;
        lat_lo    = 1;
        lat_hi    = 1;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        timed_out = 1'b0;
        check_en  = 1'b0;
        late_mode = 1'b0;
        frames    = 0;
        for (int a = 0; a < 2048; a++) begin
            rom_tab[a] = 16'($urandom);
        end
        repeat (2) @(posedge clk24);
        test_reset_values();
        @(posedge clk24);
        rst_n <= 1'b1;
        fill_memories();
        test_frame_timing();
        test_tile_image();
        test_palette_update();
        test_slow_rom();
        test_late_rom();
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures, timeout %0d",
                 tests, checks, errors, i_vid_top.i_chk.fails, timed_out);
        if (errors == 0 && i_vid_top.i_chk.fails == 0 && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
